// File: src/isaPkg.sv
package isaPkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // major opcodes, instr[31:26]
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_ADDIU = 6'b001001;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_SW    = 6'b101011;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_J     = 6'b000010;

    // funct field of R-type
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_SLT  = 6'b101010;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        SLT = 3'd4   // signed compare
    } aluOp_e;

endpackage

// File: src/pipePkg.sv
package pipePkg;

    typedef struct packed {
        logic           regWe;
        logic           useImm;    // imm replaces the rt operand
        logic           regDstRd;  // rd for R-type, rt otherwise
        logic           memRead;
        logic           memWrite;
        isaPkg::aluOp_e aluOp;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                         ctrl;
        logic [isaPkg::REG_ADDR_W-1:0] rs;
        logic [isaPkg::REG_ADDR_W-1:0] rt;
        logic [isaPkg::REG_ADDR_W-1:0] rd;
        logic [isaPkg::XLEN-1:0]       rsData;
        logic [isaPkg::XLEN-1:0]       rtData;
        logic [isaPkg::XLEN-1:0]       imm;
        logic [isaPkg::XLEN-1:0]       pc;
    } idEx_t;

    typedef struct packed {
        logic                          regWe;
        logic                          memRead;
        logic                          memWrite;
        logic [isaPkg::REG_ADDR_W-1:0] dst;
        logic [isaPkg::XLEN-1:0]       aluResult;
        logic [isaPkg::XLEN-1:0]       storeData;
        logic [isaPkg::XLEN-1:0]       pc;
    } exMem_t;

    typedef struct packed {
        logic [isaPkg::XLEN-1:0] addr;
        logic [isaPkg::XLEN-1:0] wdata;
        logic                    en;
        logic                    we;
    } memReq_t;

    typedef struct packed {
        logic [isaPkg::XLEN-1:0]       pc;
        logic                          we;
        logic [isaPkg::REG_ADDR_W-1:0] dst;
        logic [isaPkg::XLEN-1:0]       data;
    } wbDebug_t;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwdSel_e;

endpackage

// File: src/instrFetch.sv
`timescale 1ns/1ps

module instrFetch (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    stall_i,
    input  logic                    takeBranch_i,
    input  logic                    takeJump_i,
    input  logic [isaPkg::XLEN-1:0] branchTarget_i,
    input  logic [isaPkg::XLEN-1:0] jumpTarget_i,
    output logic [isaPkg::XLEN-1:0] pc_o,
    output logic [isaPkg::XLEN-1:0] pcPlus4_o,
    output logic                    instrEn_o
);

    logic [isaPkg::XLEN-1:0] pcNext;

    assign pcPlus4_o = pc_o + 'd4;
    assign instrEn_o = ~stall_i;  // imem keeps instr_i while low

    // the delay slot is already being fetched when decode redirects
    always_comb begin
        if (takeJump_i) begin
            pcNext = jumpTarget_i;
        end else if (takeBranch_i) begin
            pcNext = branchTarget_i;
        end else begin
            pcNext = pcPlus4_o;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_o <= isaPkg::RESET_PC;
        end else if (!stall_i) begin
            pc_o <= pcNext;
        end
    end

endmodule

// File: src/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic [isaPkg::REG_ADDR_W-1:0] raddrA_i,
    input  logic [isaPkg::REG_ADDR_W-1:0] raddrB_i,
    output logic [isaPkg::XLEN-1:0]       rdataA_o,
    output logic [isaPkg::XLEN-1:0]       rdataB_o,
    input  pipePkg::wbDebug_t             wb_i
);

    logic [isaPkg::XLEN-1:0] regs [2**isaPkg::REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 2**isaPkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && wb_i.dst != '0) begin
            regs[wb_i.dst] <= wb_i.data;
        end
    end

    // same-cycle write is visible to decode
    function automatic logic [isaPkg::XLEN-1:0] readPort(
        input logic [isaPkg::REG_ADDR_W-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end
        if (wb_i.we && wb_i.dst == addr) begin
            return wb_i.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdataA_o = readPort(raddrA_i);
        rdataB_o = readPort(raddrB_i);
    end

endmodule

// File: src/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic [isaPkg::XLEN-1:0]       instr_i,
    input  logic [isaPkg::XLEN-1:0]       pcPlus4_i,
    input  logic                          stall_i,
    input  logic                          fwdBranchA_i,
    input  logic                          fwdBranchB_i,
    input  logic [isaPkg::XLEN-1:0]       memForward_i,
    input  logic [isaPkg::XLEN-1:0]       rdataA_i,
    input  logic [isaPkg::XLEN-1:0]       rdataB_i,
    output logic [isaPkg::REG_ADDR_W-1:0] rs_o,
    output logic [isaPkg::REG_ADDR_W-1:0] rt_o,
    output logic                          isBranch_o,
    output logic                          takeBranch_o,
    output logic                          takeJump_o,
    output logic [isaPkg::XLEN-1:0]       branchTarget_o,
    output logic [isaPkg::XLEN-1:0]       jumpTarget_o,
    output pipePkg::idEx_t                idEx_o
);

    logic [isaPkg::XLEN-1:0]       pcPlus4D;  // pc+4 of the word on instr_i
    logic [5:0]                    opcode;
    logic [5:0]                    funct;
    logic [isaPkg::REG_ADDR_W-1:0] rd;
    logic [isaPkg::XLEN-1:0]       imm;
    logic [isaPkg::XLEN-1:0]       cmpA;
    logic [isaPkg::XLEN-1:0]       cmpB;
    pipePkg::ctrl_t                ctrl;

    assign opcode = instr_i[31:26];
    assign rs_o   = instr_i[25:21];
    assign rt_o   = instr_i[20:16];
    assign rd     = instr_i[15:11];
    assign funct  = instr_i[5:0];
    assign imm    = {{16{instr_i[15]}}, instr_i[15:0]};

    always_comb begin
        ctrl = '0;  // nop and anything unsupported
        case (opcode)
            isaPkg::OP_RTYPE: begin
                ctrl.regWe    = 1'b1;
                ctrl.regDstRd = 1'b1;
                case (funct)
                    isaPkg::FN_ADDU: ctrl.aluOp = isaPkg::ADD;
                    isaPkg::FN_SUBU: ctrl.aluOp = isaPkg::SUB;
                    isaPkg::FN_AND:  ctrl.aluOp = isaPkg::AND;
                    isaPkg::FN_OR:   ctrl.aluOp = isaPkg::OR;
                    isaPkg::FN_SLT:  ctrl.aluOp = isaPkg::SLT;
                    default:         ctrl.regWe = 1'b0;
                endcase
            end
            isaPkg::OP_ADDIU: begin
                ctrl.regWe  = 1'b1;
                ctrl.useImm = 1'b1;
            end
            isaPkg::OP_LW: begin
                ctrl.regWe   = 1'b1;
                ctrl.useImm  = 1'b1;
                ctrl.memRead = 1'b1;
            end
            isaPkg::OP_SW: begin
                ctrl.useImm   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            default: ctrl = '0;  // beq and j write nothing
        endcase
    end

    // beq compare, mem stage result forwarded in
    assign cmpA = fwdBranchA_i ? memForward_i : rdataA_i;
    assign cmpB = fwdBranchB_i ? memForward_i : rdataB_i;

    assign isBranch_o     = opcode == isaPkg::OP_BEQ;
    assign takeBranch_o   = isBranch_o && cmpA == cmpB;
    assign takeJump_o     = opcode == isaPkg::OP_J;
    assign branchTarget_o = pcPlus4D + {imm[29:0], 2'b00};
    assign jumpTarget_o   = {pcPlus4D[31:28], instr_i[25:0], 2'b00};

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pcPlus4D <= pcPlus4_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || stall_i) begin
            idEx_o.ctrl <= '0;  // bubble into execute
        end else begin
            idEx_o.ctrl <= ctrl;
        end
        idEx_o.rs     <= rs_o;
        idEx_o.rt     <= rt_o;
        idEx_o.rd     <= rd;
        idEx_o.rsData <= rdataA_i;
        idEx_o.rtData <= rdataB_i;
        idEx_o.imm    <= imm;
        idEx_o.pc     <= pcPlus4D - 'd4;
    end

endmodule

// File: src/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input  logic [isaPkg::REG_ADDR_W-1:0] idRs_i,
    input  logic [isaPkg::REG_ADDR_W-1:0] idRt_i,
    input  logic [isaPkg::REG_ADDR_W-1:0] exRs_i,
    input  logic [isaPkg::REG_ADDR_W-1:0] exRt_i,
    input  logic [isaPkg::REG_ADDR_W-1:0] exDst_i,
    input  logic                          exRegWe_i,
    input  logic                          exMemRead_i,
    input  logic [isaPkg::REG_ADDR_W-1:0] memDst_i,
    input  logic                          memRegWe_i,
    input  logic                          memMemRead_i,
    input  logic [isaPkg::REG_ADDR_W-1:0] wbDst_i,
    input  logic                          wbRegWe_i,
    input  logic                          isBranch_i,
    output logic                          stall_o,
    output pipePkg::fwdSel_e              fwdA_o,
    output pipePkg::fwdSel_e              fwdB_o,
    output logic                          fwdBranchA_o,
    output logic                          fwdBranchB_o
);

    logic loadUse;
    logic branchOnEx;
    logic branchOnLoad;

    // producer writes src, r0 excluded
    function automatic logic writes(
        input logic                          we,
        input logic [isaPkg::REG_ADDR_W-1:0] dst,
        input logic [isaPkg::REG_ADDR_W-1:0] src
    );
        return we && dst != '0 && dst == src;
    endfunction

    function automatic pipePkg::fwdSel_e pick(input logic [isaPkg::REG_ADDR_W-1:0] src);
        if (writes(memRegWe_i, memDst_i, src)) begin
            return pipePkg::FWD_MEM;  // youngest wins
        end
        if (writes(wbRegWe_i, wbDst_i, src)) begin
            return pipePkg::FWD_WB;
        end
        return pipePkg::FWD_REG;
    endfunction

    always_comb begin
        loadUse = writes(exMemRead_i, exDst_i, idRs_i) || writes(exMemRead_i, exDst_i, idRt_i);
        branchOnEx = isBranch_i
            && (writes(exRegWe_i, exDst_i, idRs_i) || writes(exRegWe_i, exDst_i, idRt_i));
        branchOnLoad = isBranch_i
            && (writes(memMemRead_i, memDst_i, idRs_i) || writes(memMemRead_i, memDst_i, idRt_i));
        stall_o = loadUse || branchOnEx || branchOnLoad;

        fwdA_o = pick(exRs_i);
        fwdB_o = pick(exRt_i);
        fwdBranchA_o = writes(memRegWe_i, memDst_i, idRs_i);
        fwdBranchB_o = writes(memRegWe_i, memDst_i, idRt_i);
    end

endmodule

// File: src/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic                          clk,
    input  logic                          reset_i,
    input  pipePkg::idEx_t                idEx_i,
    input  pipePkg::fwdSel_e              fwdA_i,
    input  pipePkg::fwdSel_e              fwdB_i,
    input  logic [isaPkg::XLEN-1:0]       memForward_i,
    input  logic [isaPkg::XLEN-1:0]       wbForward_i,
    output logic [isaPkg::REG_ADDR_W-1:0] dst_o,
    output pipePkg::exMem_t               exMem_o
);

    logic [isaPkg::XLEN-1:0] opA;
    logic [isaPkg::XLEN-1:0] rtFwd;  // also the store data
    logic [isaPkg::XLEN-1:0] opB;
    logic [isaPkg::XLEN-1:0] aluResult;

    function automatic logic [isaPkg::XLEN-1:0] fwdMux(
        input pipePkg::fwdSel_e        sel,
        input logic [isaPkg::XLEN-1:0] regVal,
        input logic [isaPkg::XLEN-1:0] memVal,
        input logic [isaPkg::XLEN-1:0] wbVal
    );
        case (sel)
            pipePkg::FWD_MEM: return memVal;
            pipePkg::FWD_WB:  return wbVal;
            default:          return regVal;
        endcase
    endfunction

    assign opA   = fwdMux(fwdA_i, idEx_i.rsData, memForward_i, wbForward_i);
    assign rtFwd = fwdMux(fwdB_i, idEx_i.rtData, memForward_i, wbForward_i);
    assign opB   = idEx_i.ctrl.useImm ? idEx_i.imm : rtFwd;
    assign dst_o = idEx_i.ctrl.regDstRd ? idEx_i.rd : idEx_i.rt;

    always_comb begin
        case (idEx_i.ctrl.aluOp)
            isaPkg::SUB: aluResult = opA - opB;
            isaPkg::AND: aluResult = opA & opB;
            isaPkg::OR:  aluResult = opA | opB;
            isaPkg::SLT: aluResult = {{(isaPkg::XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            default:     aluResult = opA + opB;  // also lw/sw address
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            exMem_o.regWe    <= 1'b0;
            exMem_o.memRead  <= 1'b0;
            exMem_o.memWrite <= 1'b0;
        end else begin
            exMem_o.regWe    <= idEx_i.ctrl.regWe;
            exMem_o.memRead  <= idEx_i.ctrl.memRead;
            exMem_o.memWrite <= idEx_i.ctrl.memWrite;
        end
        exMem_o.dst       <= dst_o;
        exMem_o.aluResult <= aluResult;
        exMem_o.storeData <= rtFwd;
        exMem_o.pc        <= idEx_i.pc;
    end

endmodule

// File: src/memWriteback.sv
`timescale 1ns/1ps

module memWriteback (
    input  logic                    clk,
    input  logic                    reset_i,
    input  pipePkg::exMem_t         exMem_i,
    input  logic [isaPkg::XLEN-1:0] memRdata_i,
    output pipePkg::memReq_t        memReq_o,
    output logic [isaPkg::XLEN-1:0] memForward_o,
    output pipePkg::wbDebug_t       wb_o
);

    pipePkg::wbDebug_t wbReg;  // data holds the ALU result
    logic              memReadW;

    assign memReq_o = '{
        addr:  exMem_i.aluResult,
        wdata: exMem_i.storeData,
        en:    exMem_i.memRead || exMem_i.memWrite,
        we:    exMem_i.memWrite
    };
    assign memForward_o = exMem_i.aluResult;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wbReg.we <= 1'b0;
            memReadW <= 1'b0;
        end else begin
            wbReg.we <= exMem_i.regWe;
            memReadW <= exMem_i.memRead;
        end
        wbReg.pc   <= exMem_i.pc;
        wbReg.dst  <= exMem_i.dst;
        wbReg.data <= exMem_i.aluResult;
    end

    // load data arrives one cycle after the request
    always_comb begin
        wb_o = wbReg;
        if (memReadW) begin
            wb_o.data = memRdata_i;
        end
    end

endmodule

// File: src/mipsPipeline.sv
`timescale 1ns/1ps

module mipsPipeline (
    input  logic                    clk,
    input  logic                    reset_i,
    output logic [isaPkg::XLEN-1:0] pc_o,
    output logic                    instrEn_o,
    input  logic [isaPkg::XLEN-1:0] instr_i,
    output pipePkg::memReq_t        memReq_o,
    input  logic [isaPkg::XLEN-1:0] memRdata_i,
    output pipePkg::wbDebug_t       debugWb_o
);

    logic                          stall;
    logic                          takeBranch;
    logic                          takeJump;
    logic                          isBranch;
    logic                          fwdBranchA;
    logic                          fwdBranchB;
    logic [isaPkg::XLEN-1:0]       pcPlus4;
    logic [isaPkg::XLEN-1:0]       branchTarget;
    logic [isaPkg::XLEN-1:0]       jumpTarget;
    logic [isaPkg::XLEN-1:0]       rdataA;
    logic [isaPkg::XLEN-1:0]       rdataB;
    logic [isaPkg::XLEN-1:0]       memForward;
    logic [isaPkg::REG_ADDR_W-1:0] idRs;
    logic [isaPkg::REG_ADDR_W-1:0] idRt;
    logic [isaPkg::REG_ADDR_W-1:0] exDst;
    pipePkg::idEx_t                idEx;
    pipePkg::exMem_t               exMem;
    pipePkg::fwdSel_e              fwdA;
    pipePkg::fwdSel_e              fwdB;

    instrFetch fetch0 (
        .clk            (clk),
        .reset_i        (reset_i),
        .stall_i        (stall),
        .takeBranch_i   (takeBranch),
        .takeJump_i     (takeJump),
        .branchTarget_i (branchTarget),
        .jumpTarget_i   (jumpTarget),
        .pc_o           (pc_o),
        .pcPlus4_o      (pcPlus4),
        .instrEn_o      (instrEn_o)
    );

    regFile regs0 (
        .clk      (clk),
        .reset_i  (reset_i),
        .raddrA_i (idRs),
        .raddrB_i (idRt),
        .rdataA_o (rdataA),
        .rdataB_o (rdataB),
        .wb_i     (debugWb_o)
    );

    decodeStage decode0 (
        .clk            (clk),
        .reset_i        (reset_i),
        .instr_i        (instr_i),
        .pcPlus4_i      (pcPlus4),
        .stall_i        (stall),
        .fwdBranchA_i   (fwdBranchA),
        .fwdBranchB_i   (fwdBranchB),
        .memForward_i   (memForward),
        .rdataA_i       (rdataA),
        .rdataB_i       (rdataB),
        .rs_o           (idRs),
        .rt_o           (idRt),
        .isBranch_o     (isBranch),
        .takeBranch_o   (takeBranch),
        .takeJump_o     (takeJump),
        .branchTarget_o (branchTarget),
        .jumpTarget_o   (jumpTarget),
        .idEx_o         (idEx)
    );

    hazardUnit hazard0 (
        .idRs_i       (idRs),
        .idRt_i       (idRt),
        .exRs_i       (idEx.rs),
        .exRt_i       (idEx.rt),
        .exDst_i      (exDst),
        .exRegWe_i    (idEx.ctrl.regWe),
        .exMemRead_i  (idEx.ctrl.memRead),
        .memDst_i     (exMem.dst),
        .memRegWe_i   (exMem.regWe),
        .memMemRead_i (exMem.memRead),
        .wbDst_i      (debugWb_o.dst),
        .wbRegWe_i    (debugWb_o.we),
        .isBranch_i   (isBranch),
        .stall_o      (stall),
        .fwdA_o       (fwdA),
        .fwdB_o       (fwdB),
        .fwdBranchA_o (fwdBranchA),
        .fwdBranchB_o (fwdBranchB)
    );

    executeStage execute0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .idEx_i       (idEx),
        .fwdA_i       (fwdA),
        .fwdB_i       (fwdB),
        .memForward_i (memForward),
        .wbForward_i  (debugWb_o.data),
        .dst_o        (exDst),
        .exMem_o      (exMem)
    );

    memWriteback memWb0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .exMem_i      (exMem),
        .memRdata_i   (memRdata_i),
        .memReq_o     (memReq_o),
        .memForward_o (memForward),
        .wb_o         (debugWb_o)
    );

endmodule

// File: sim/pipeline_properties.sv
`timescale 1ns/1ps

module pipelineProperties (
    input logic                    clk,
    input logic                    reset_i,
    input logic [isaPkg::XLEN-1:0] pc_i,
    input logic                    instrEn_i,
    input pipePkg::memReq_t        memReq_i,
    input pipePkg::wbDebug_t       debugWb_i
);

    storeHasEnable: assert property (@(posedge clk) disable iff (reset_i)
        memReq_i.we |-> memReq_i.en)
        else $error("store request without enable");

    wordAligned: assert property (@(posedge clk) disable iff (reset_i)
        memReq_i.en |-> memReq_i.addr[1:0] == 2'b00)
        else $error("unaligned data address %h", $sampled(memReq_i.addr));

    // one edge in reset clears the stage flags
    quietInReset: assert property (@(posedge clk)
        reset_i ##1 reset_i |-> !debugWb_i.we && !memReq_i.en)
        else $error("writeback or memory request during reset");

    pcHoldsOnStall: assert property (@(posedge clk) disable iff (reset_i)
        !instrEn_i |=> $stable(pc_i))
        else $error("pc moved while fetch was disabled");

endmodule

bind mipsPipeline pipelineProperties props0 (
    .clk       (clk),
    .reset_i   (reset_i),
    .pc_i      (pc_o),
    .instrEn_i (instrEn_o),
    .memReq_i  (memReq_o),
    .debugWb_i (debugWb_o)
);

// File: sim/mipsPipelineTb.sv
`timescale 1ns/1ps

module mipsPipelineTb;

    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;
    localparam int PROG_WORDS = 31;
    localparam int NUM_WB     = 21;
    localparam int NUM_STORES = 2;
    localparam int NUM_STALLS = 5;   // load-use and beq stall cycles of the program
    localparam int WAIT_LIMIT = 40;  // cycles between two writebacks
    localparam logic [31:0] SEED = 32'h20be0821;

    typedef struct {
        logic [31:0] pc;
        logic [4:0]  dst;
        logic [31:0] data;     // preload word index when fromMem
        bit          fromMem;
    } wbRow_t;

    logic                    clk;
    logic                    reset;
    logic [isaPkg::XLEN-1:0] pc;
    logic                    instrEn;
    logic [isaPkg::XLEN-1:0] instr;
    pipePkg::memReq_t        memReq;
    logic [isaPkg::XLEN-1:0] memRdata;
    pipePkg::wbDebug_t       debugWb;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] memInit [DMEM_WORDS];  // untouched copy of the preload
    logic [31:0] progTable [PROG_WORDS];
    int          storeIdx = 0;
    int          stallCycles = 0;

    // pc, dst, data in program order
    wbRow_t wbTable [NUM_WB] = '{
        '{32'h00, 5'd1,  32'h0000_0005, 1'b0},
        '{32'h04, 5'd2,  32'hffff_fffd, 1'b0},
        '{32'h08, 5'd3,  32'h0000_0002, 1'b0},
        '{32'h0c, 5'd4,  32'hffff_fffd, 1'b0},
        '{32'h10, 5'd5,  32'h0000_0005, 1'b0},
        '{32'h14, 5'd6,  32'hffff_fffd, 1'b0},
        '{32'h18, 5'd7,  32'h0000_0001, 1'b0},
        '{32'h1c, 5'd8,  32'h0000_0000, 1'b0},
        '{32'h20, 5'd10, 32'h0000_0040, 1'b0},
        '{32'h24, 5'd11, 32'hffff_fffe, 1'b0},
        '{32'h2c, 5'd12, 32'hffff_fffe, 1'b0},
        '{32'h30, 5'd13, 32'h0000_0003, 1'b0},
        '{32'h34, 5'd15, 32'hffff_fffe, 1'b0},
        '{32'h38, 5'd14, 32'hffff_fffe, 1'b0},
        '{32'h40, 5'd16, 32'h0000_0007, 1'b0},
        '{32'h48, 5'd18, 32'h0000_0003, 1'b0},
        '{32'h50, 5'd19, 32'h0000_0003, 1'b0},
        '{32'h58, 5'd20, 32'h0000_0009, 1'b0},
        '{32'h64, 5'd23, 32'h0000_0002, 1'b0},
        '{32'h6c, 5'd24, 32'd18,        1'b1},
        '{32'h70, 5'd25, 32'd18,        1'b1}
    };

    pipePkg::memReq_t storeTable [NUM_STORES] = '{
        '{addr: 32'h44, wdata: 32'hffff_fffe, en: 1'b1, we: 1'b1},
        '{addr: 32'h40, wdata: 32'h0000_0002, en: 1'b1, we: 1'b1}
    };

    mipsPipeline dut0 (
        .clk        (clk),
        .reset_i    (reset),
        .pc_o       (pc),
        .instrEn_o  (instrEn),
        .instr_i    (instr),
        .memReq_o   (memReq),
        .memRdata_i (memRdata),
        .debugWb_o  (debugWb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] rType(input logic [5:0] funct, input int rd, input int rs,
                                          input int rt);
        return {isaPkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input int rt, input int rs,
                                          input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] jType(input int index);
        return {isaPkg::OP_J, 26'(index)};
    endfunction

    // synchronous imem, holds while instrEn is low
    always @(posedge clk) begin
        if (reset) begin
            instr <= #2 '0;
        end else if (instrEn) begin
            instr <= #2 imem[pc[7:2]];
        end
    end

    always @(posedge clk) begin
        if (memReq.en === 1'b1) begin
            if (memReq.we) begin
                dmem[memReq.addr[7:2]] <= memReq.wdata;
            end else begin
                memRdata <= #2 dmem[memReq.addr[7:2]];  // seen by writeback next cycle
            end
        end
    end

    task automatic failNow();
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkFetch(input logic [isaPkg::XLEN-1:0] actualPc, input logic actualEn);
        bit bad;
        bad = 1'b0;
        if (actualPc !== isaPkg::RESET_PC) begin
            $display("ERR pc_o got %h expected %h", actualPc, isaPkg::RESET_PC);
            bad = 1'b1;
        end
        if (actualEn !== 1'b1) begin
            $display("ERR instrEn_o got %h expected %h", actualEn, 1'b1);
            bad = 1'b1;
        end
        if (bad) begin
            failNow();
        end
    endtask

    task automatic checkWb(input pipePkg::wbDebug_t actual, input pipePkg::wbDebug_t expected);
        bit bad;
        bad = 1'b0;
        if (actual.pc !== expected.pc) begin
            $display("ERR debugWb_o.pc got %h expected %h", actual.pc, expected.pc);
            bad = 1'b1;
        end
        if (actual.dst !== expected.dst) begin
            $display("ERR debugWb_o.dst got %h expected %h", actual.dst, expected.dst);
            bad = 1'b1;
        end
        if (actual.data !== expected.data) begin
            $display("ERR debugWb_o.data got %h expected %h", actual.data, expected.data);
            bad = 1'b1;
        end
        if (bad) begin
            failNow();
        end
    endtask

    task automatic checkStore(input pipePkg::memReq_t actual, input pipePkg::memReq_t expected);
        bit bad;
        bad = 1'b0;
        if (actual.addr !== expected.addr) begin
            $display("ERR memReq_o.addr got %h expected %h", actual.addr, expected.addr);
            bad = 1'b1;
        end
        if (actual.wdata !== expected.wdata) begin
            $display("ERR memReq_o.wdata got %h expected %h", actual.wdata, expected.wdata);
            bad = 1'b1;
        end
        if (actual.en !== expected.en) begin
            $display("ERR memReq_o.en got %h expected %h", actual.en, expected.en);
            bad = 1'b1;
        end
        if (bad) begin
            failNow();
        end
    endtask

    // next retired write, sampled mid-cycle
    task automatic waitWb(output pipePkg::wbDebug_t actual);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (debugWb.we !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                $display("no writeback within %0d cycles", WAIT_LIMIT);
                failNow();
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
        actual = debugWb;
    endtask

    always @(negedge clk) begin
        if (!reset && memReq.we === 1'b1) begin
            if (storeIdx >= NUM_STORES) begin
                $display("unexpected store to address %h", memReq.addr);
                failNow();
            end else begin
                checkStore(memReq, storeTable[storeIdx]);
                storeIdx++;
            end
        end
    end

    always @(negedge clk) begin
        if (!reset && instrEn !== 1'b1) begin
            stallCycles++;  // fetch disabled
        end
    end

    initial begin : mainFlow
        pipePkg::wbDebug_t actual;
        pipePkg::wbDebug_t expected;
        reset    = 1'b1;
        instr    = '0;
        memRdata = '0;
        void'($urandom(SEED));
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]    = $urandom();
            memInit[i] = dmem[i];
        end
        progTable = '{
            iType(isaPkg::OP_ADDIU, 1, 0, 5),
            iType(isaPkg::OP_ADDIU, 2, 0, -3),
            rType(isaPkg::FN_ADDU, 3, 1, 2),    // mem and wb forwarding
            rType(isaPkg::FN_SUBU, 4, 3, 1),
            rType(isaPkg::FN_AND, 5, 4, 1),
            rType(isaPkg::FN_OR, 6, 5, 2),
            rType(isaPkg::FN_SLT, 7, 2, 1),
            rType(isaPkg::FN_SLT, 8, 1, 2),
            iType(isaPkg::OP_ADDIU, 10, 0, 'h40),
            rType(isaPkg::FN_ADDU, 11, 6, 7),
            iType(isaPkg::OP_SW, 11, 10, 4),    // rt forwarded from mem
            iType(isaPkg::OP_LW, 12, 10, 4),
            rType(isaPkg::FN_ADDU, 13, 12, 1),  // load-use
            rType(isaPkg::FN_ADDU, 15, 12, 0),
            iType(isaPkg::OP_LW, 14, 10, 4),
            iType(isaPkg::OP_BEQ, 15, 14, 2),   // taken after two stalls
            iType(isaPkg::OP_ADDIU, 16, 0, 7),  // delay slot
            iType(isaPkg::OP_ADDIU, 17, 0, 1),
            rType(isaPkg::FN_ADDU, 18, 14, 1),
            iType(isaPkg::OP_BEQ, 1, 18, 3),    // not taken
            rType(isaPkg::FN_OR, 19, 18, 7),
            jType(25),
            iType(isaPkg::OP_ADDIU, 20, 0, 9),
            iType(isaPkg::OP_ADDIU, 21, 0, 2),
            iType(isaPkg::OP_ADDIU, 22, 0, 4),
            rType(isaPkg::FN_SUBU, 23, 20, 16),
            iType(isaPkg::OP_SW, 23, 10, 0),
            iType(isaPkg::OP_LW, 24, 10, 8),    // random preload word
            rType(isaPkg::FN_AND, 25, 24, 24),
            jType(29),                          // spin
            32'h0000_0000
        };
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < PROG_WORDS) ? progTable[i] : 32'h0;
        end

        repeat (5) @(posedge clk);
        #2 reset = 1'b0;

        // first fetch cycle after reset
        @(negedge clk);
        checkFetch(pc, instrEn);

        for (int i = 0; i < NUM_WB; i++) begin
            waitWb(actual);
            expected.pc   = wbTable[i].pc;
            expected.we   = 1'b1;
            expected.dst  = wbTable[i].dst;
            expected.data = wbTable[i].fromMem ? memInit[wbTable[i].data] : wbTable[i].data;
            checkWb(actual, expected);
        end

        // the spin loop and skipped slots retire nothing
        repeat (20) begin
            @(negedge clk);
            if (debugWb.we !== 1'b0) begin
                $display("extra writeback from pc %h", debugWb.pc);
                failNow();
            end
        end

        if (stallCycles != NUM_STALLS) begin
            $display("ERR instrEn_o low for %h cycles expected %h", stallCycles, NUM_STALLS);
            failNow();
        end else if (storeIdx != NUM_STORES) begin
            $display("saw %0d stores, expected %0d", storeIdx, NUM_STORES);
            $display("Verification failed");
            $fatal(1, "store count mismatch");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// File: mipsPipeline.f
src/isaPkg.sv
src/pipePkg.sv
src/instrFetch.sv
src/regFile.sv
src/decodeStage.sv
src/hazardUnit.sv
src/executeStage.sv
src/memWriteback.sv
src/mipsPipeline.sv
sim/pipeline_properties.sv
sim/mipsPipelineTb.sv

// File: Bender.yml
package:
  name: mipsPipeline

sources:
  - src/isaPkg.sv
  - src/pipePkg.sv
  - src/instrFetch.sv
  - src/regFile.sv
  - src/decodeStage.sv
  - src/hazardUnit.sv
  - src/executeStage.sv
  - src/memWriteback.sv
  - src/mipsPipeline.sv
  - target: simulation
    files:
      - sim/pipeline_properties.sv
      - sim/mipsPipelineTb.sv
